/* bench/engine_cases.txt */
# name op kind reps accepted money level hp_enemy hp_army enemy_count army_count win lose
# op 0 spawn enemy, 1 buy army, 2 upgrade, 3 tick; accepted is ignored on tick lines
tick_income    3 0   5 0   5 0 200 200 0 0 0 0
upgrade_poor   2 0   1 0   5 0 200 200 0 0 0 0
tick_cap       3 0 100 0 100 0 200 200 0 0 0 0
upgrade_ok     2 0   1 1  60 1 200 200 0 0 0 0
tick_level1    3 0   3 0  66 1 200 200 0 0 0 0
buy_pike       1 0   1 1  16 1 200 200 0 1 0 0
buy_poor       1 1   1 0  16 1 200 200 0 1 0 0
pike_alive     3 0  19 0  54 1 105 200 0 1 0 0
pike_expire    3 0   1 0  56 1 100 200 0 0 0 0
spawn_fill     0 0   8 1  56 1 100 200 8 0 0 0
spawn_full     0 3   1 0  56 1 100 200 8 0 0 0
tick_hit       3 0   3 0  62 1 100 104 8 0 0 0
tick_lose      3 0   4 0  70 1 100   0 8 0 0 1
tick_ignored   3 0   3 0  70 1 100   0 8 0 0 1
buy_over       1 0   1 0  70 1 100   0 8 0 0 1
upgrade_over   2 0   1 0  70 1 100   0 8 0 0 1

/* bench/game_engine_assert.sv */
`timescale 1ns/1ns

module game_engine_assert (
    input  logic                clk_25MHz,
    input  logic                rst,
    input  logic                req,
    input  logic                ack,
    input  engine_pkg::money_t  money,
    input  engine_pkg::level_t  purse_level,
    input  engine_pkg::hp_t     tower_hp_enemy,
    input  engine_pkg::hp_t     tower_hp_army
);

    // --------------------
    // handshake

    ack_needs_req: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(ack) |-> req)
        else $error("ack rose while req was low");

    ack_low_after_reset: assert property (@(posedge clk_25MHz) rst |=> !ack)
        else $error("ack high in the cycle after reset");

    // --------------------
    // ledgers

    enemy_tower_falls: assert property (@(posedge clk_25MHz) disable iff (rst)
        $past(tower_hp_enemy) >= tower_hp_enemy)
        else $error("enemy tower health increased");

    army_tower_falls: assert property (@(posedge clk_25MHz) disable iff (rst)
        $past(tower_hp_army) >= tower_hp_army)
        else $error("army tower health increased");

    money_in_cap: assert property (@(posedge clk_25MHz) disable iff (rst)
        money <= engine_pkg::money_cap(purse_level))
        else $error("money above the cap of the purse level");

endmodule

bind game_engine game_engine_assert game_engine_assert_inst (
    .clk_25MHz      (clk_25MHz),
    .rst            (rst),
    .req            (req),
    .ack            (ack),
    .money          (money),
    .purse_level    (purse_level),
    .tower_hp_enemy (tower_hp_enemy),
    .tower_hp_army  (tower_hp_army)
);

/* bench/game_engine_tb.sv */
`timescale 1ns/1ns

module game_engine_tb;

    localparam int TIMEOUT = 20;  // cycles per wait

    logic                clk_25MHz = 1'b0;
    logic                rst;
    logic                tick;
    logic                req;
    engine_pkg::cmd_t    cmd;
    logic                ack;
    engine_pkg::resp_t   resp;
    logic                busy;
    engine_pkg::money_t  money;
    engine_pkg::level_t  purse_level;
    engine_pkg::hp_t     tower_hp_enemy;
    engine_pkg::hp_t     tower_hp_army;
    logic [3:0]          enemy_count;
    logic [3:0]          army_count;
    logic                game_win;
    logic                game_lose;

    int  bad;           // mismatches in the running test
    int  tests;
    int  failed_tests;
    bit  timed_out;

    always #20 clk_25MHz = ~clk_25MHz;

    game_engine #(
        .TOWER_HP (200)
    ) game_engine_inst (
        .clk_25MHz      (clk_25MHz),
        .rst            (rst),
        .tick           (tick),
        .req            (req),
        .cmd            (cmd),
        .ack            (ack),
        .resp           (resp),
        .busy           (busy),
        .money          (money),
        .purse_level    (purse_level),
        .tower_hp_enemy (tower_hp_enemy),
        .tower_hp_army  (tower_hp_army),
        .enemy_count    (enemy_count),
        .army_count     (army_count),
        .game_win       (game_win),
        .game_lose      (game_lose)
    );

    // --------------------
    // helpers

    function automatic string text_of(input logic [8*24-1:0] raw);
        string s;
        s = "";
        for (int i = 23; i >= 0; i--) begin
            if (raw[8*i +: 8] != 8'h00) s = $sformatf("%s%c", s, raw[8*i +: 8]);
        end
        return s;
    endfunction

    task automatic check_value(input string tname, input string field,
                               input int exp_v, input int act_v);
        assert (act_v == exp_v) else begin
            $display("Fail %0s %0s expected %0d actual %0d", tname, field, exp_v, act_v);
            bad++;
        end
    endtask

    task automatic wait_ack(input logic level, input string tname);
        int n;
        n = 0;
        @(negedge clk_25MHz);
        while (ack !== level && n < TIMEOUT) begin
            @(negedge clk_25MHz);
            n++;
        end
        if (ack !== level) begin
            $display("%0s: ack did not go to %0d within %0d cycles", tname, level, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_idle(input string tname);
        int n;
        n = 0;
        @(negedge clk_25MHz);
        while (busy !== 1'b0 && n < TIMEOUT) begin
            @(negedge clk_25MHz);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("%0s: engine still busy after %0d cycles", tname, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_tick(input string tname);
        @(posedge clk_25MHz);
        tick <= 1'b1;
        @(posedge clk_25MHz);
        tick <= 1'b0;
        wait_idle(tname);   // returns at once when the game is over
    endtask

    task automatic run_cmd(input logic [1:0] op_code, input logic [1:0] kind_code,
                           input int exp_acc, input string tname);
        @(posedge clk_25MHz);
        req <= 1'b1;
        cmd <= '{op: engine_pkg::cmd_op_t'(op_code), kind: kind_code};
        wait_ack(1'b1, tname);
        if (!timed_out) begin
            check_value(tname, "accepted", exp_acc, int'(resp.accepted));
            @(posedge clk_25MHz);
            req <= 1'b0;
            wait_ack(1'b0, tname);
        end
    endtask

    // --------------------
    // case runner

    initial begin
        string            line;
        string            tname;
        logic [8*24-1:0]  name_raw;
        int               fd;
        int               fields;
        int               op, kind, reps, e_acc, e_money, e_level;
        int               e_hpe, e_hpa, e_ec, e_ac, e_win, e_lose;

        rst          = 1'b1;
        tick         = 1'b0;
        req          = 1'b0;
        cmd          = '0;
        tests        = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        repeat (2) @(posedge clk_25MHz);
        rst <= 1'b0;

        fd = $fopen("bench/engine_cases.txt", "r");
        if (fd == 0) begin
            $display("case file bench/engine_cases.txt could not be opened");
            failed_tests++;
        end
        while (fd != 0 && !timed_out && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;  // header or blank
            name_raw = '0;
            fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d", name_raw,
                             op, kind, reps, e_acc, e_money, e_level,
                             e_hpe, e_hpa, e_ec, e_ac, e_win, e_lose);
            if (fields != 13) begin
                $display("case line has %0d fields instead of 13: %0s", fields, line);
                failed_tests++;
                continue;
            end
            tname = text_of(name_raw);
            bad   = 0;
            for (int r = 0; r < reps && !timed_out; r++) begin
                if (op == 3) run_tick(tname);
                else run_cmd(op[1:0], kind[1:0], e_acc, tname);
            end
            tests++;
            if (timed_out) begin
                $display("test %0s stopped by a timeout", tname);
                failed_tests++;
            end else begin
                check_value(tname, "money", e_money, int'(money));
                check_value(tname, "purse_level", e_level, int'(purse_level));
                check_value(tname, "tower_hp_enemy", e_hpe, int'(tower_hp_enemy));
                check_value(tname, "tower_hp_army", e_hpa, int'(tower_hp_army));
                check_value(tname, "enemy_count", e_ec, int'(enemy_count));
                check_value(tname, "army_count", e_ac, int'(army_count));
                check_value(tname, "game_win", e_win, int'(game_win));
                check_value(tname, "game_lose", e_lose, int'(game_lose));
                if (bad == 0) begin
                    $display("test %0s passed", tname);
                end else begin
                    $display("test %0s failed with %0d mismatches", tname, bad);
                    failed_tests++;
                end
            end
        end
        if (fd != 0) $fclose(fd);

        $display("%0d tests run, %0d passed, %0d failed", tests, tests - failed_tests,
                 failed_tests);
        if (failed_tests == 0 && tests > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* game_engine.f */
verilog/engine_pkg.sv
verilog/unit_roster.sv
verilog/purse_ledger.sv
verilog/tower_ledger.sv
verilog/engine_sequencer.sv
verilog/game_engine.sv
bench/game_engine_assert.sv
bench/game_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the game engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module game_engine_tb -f game_engine.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vgame_engine_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verilog/engine_pkg.sv */
package engine_pkg;

    typedef enum logic [1:0] {
        killer_bird,
        white_bear,
        metal_duck,
        black_bear
    } enemy_kind_t;

    typedef enum logic [1:0] {
        pike,
        archer,
        knight,
        catapult
    } army_kind_t;

    typedef logic [8:0]  power_t;   // damage per tick
    typedef logic [6:0]  life_t;    // ticks left
    typedef logic [14:0] money_t;
    typedef logic [2:0]  level_t;
    typedef logic [11:0] hp_t;

    typedef struct packed {
        enemy_kind_t kind;
        power_t      power;
        life_t       life;
    } enemy_unit_t;

    typedef struct packed {
        army_kind_t kind;
        power_t     power;
        life_t      life;
    } army_unit_t;

    typedef enum logic [1:0] {
        op_spawn_enemy,
        op_buy_army,
        op_upgrade
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t    op;
        logic [1:0] kind;
    } cmd_t;

    typedef struct packed {
        logic accepted;
    } resp_t;

    // --------------------
    // unit tables

    function automatic money_t army_cost(army_kind_t kind);
        case (kind)
            pike:    return money_t'(50);
            archer:  return money_t'(75);
            knight:  return money_t'(100);
            default: return money_t'(150);
        endcase
    endfunction

    function automatic power_t army_power(army_kind_t kind);
        case (kind)
            pike:    return power_t'(5);
            archer:  return power_t'(8);
            knight:  return power_t'(12);
            default: return power_t'(20);
        endcase
    endfunction

    function automatic life_t army_life(army_kind_t kind);
        case (kind)
            pike:    return life_t'(20);
            archer:  return life_t'(30);
            knight:  return life_t'(40);
            default: return life_t'(60);
        endcase
    endfunction

    function automatic power_t enemy_power(enemy_kind_t kind);
        case (kind)
            killer_bird: return power_t'(4);
            white_bear:  return power_t'(6);
            metal_duck:  return power_t'(10);
            default:     return power_t'(16);
        endcase
    endfunction

    function automatic life_t enemy_life(enemy_kind_t kind);
        case (kind)
            killer_bird: return life_t'(25);
            white_bear:  return life_t'(35);
            metal_duck:  return life_t'(45);
            default:     return life_t'(60);
        endcase
    endfunction

    // --------------------
    // purse tables

    function automatic money_t upgrade_cost(level_t level);
        return money_t'(40) * (money_t'(level) + money_t'(1));
    endfunction

    function automatic money_t money_cap(level_t level);
        return money_t'(100) * (money_t'(level) + money_t'(1));
    endfunction

    function automatic money_t income(level_t level);
        case (level)
            3'd0:      return money_t'(1);
            3'd1, 3'd2: return money_t'(2);
            3'd3:      return money_t'(3);
            3'd4:      return money_t'(4);
            default:   return money_t'(5);
        endcase
    endfunction

endpackage

/* verilog/engine_sequencer.sv */
`timescale 1ns/1ns

module engine_sequencer (
    input  logic                      clk_25MHz,
    input  logic                      rst,
    input  logic                      tick,
    input  logic                      req,
    input  engine_pkg::cmd_t          cmd,
    input  logic                      enemy_has_free,
    input  logic                      army_has_free,
    input  logic                      can_afford,
    input  logic                      can_upgrade,
    input  logic                      game_over,
    output logic                      ack,
    output engine_pkg::resp_t         resp,
    output logic                      busy,
    output logic                      step,
    output logic                      strike,
    output logic                      enemy_spawn,
    output engine_pkg::enemy_unit_t   enemy_payload,
    output logic                      army_spawn,
    output engine_pkg::army_unit_t    army_payload,
    output logic                      buy,
    output engine_pkg::army_kind_t    buy_kind,
    output logic                      upgrade
);

    typedef enum logic [2:0] {
        st_idle,
        st_decide,
        st_respond,
        st_release,
        st_step,
        st_strike
    } state_t;

    state_t                   state;
    logic                     tick_pend;
    logic                     accept;
    engine_pkg::enemy_kind_t  enemy_kind;

    // --------------------
    // payloads and accept decision

    assign enemy_kind = engine_pkg::enemy_kind_t'(cmd.kind);
    assign buy_kind   = engine_pkg::army_kind_t'(cmd.kind);  // purse prices this kind

    assign enemy_payload = '{kind:  enemy_kind,
                             power: engine_pkg::enemy_power(enemy_kind),
                             life:  engine_pkg::enemy_life(enemy_kind)};
    assign army_payload  = '{kind:  buy_kind,
                             power: engine_pkg::army_power(buy_kind),
                             life:  engine_pkg::army_life(buy_kind)};

    always_comb begin
        case (cmd.op)
            engine_pkg::op_spawn_enemy: accept = enemy_has_free;
            engine_pkg::op_buy_army:    accept = can_afford && army_has_free;
            engine_pkg::op_upgrade:     accept = can_upgrade;
            default:                    accept = 1'b0;
        endcase
        accept = accept && !game_over;
    end

    // actions fire in the decide cycle only
    assign enemy_spawn = (state == st_decide) && accept && (cmd.op == engine_pkg::op_spawn_enemy);
    assign army_spawn  = (state == st_decide) && accept && (cmd.op == engine_pkg::op_buy_army);
    assign buy         = army_spawn;
    assign upgrade     = (state == st_decide) && accept && (cmd.op == engine_pkg::op_upgrade);

    assign step   = (state == st_step);
    assign strike = (state == st_strike);
    assign busy   = tick_pend || step || strike;

    // --------------------
    // FSM

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            state     <= st_idle;
            tick_pend <= 1'b0;
            ack       <= 1'b0;
            resp      <= '0;
        end else begin
            if (tick && !game_over) begin
                tick_pend <= 1'b1;           // repeats fold into one
            end else if (state == st_idle && tick_pend) begin
                tick_pend <= 1'b0;
            end

            case (state)
                st_idle: begin
                    if (tick_pend) state <= st_step;  // ticks first
                    else if (req)  state <= st_decide;
                end
                st_decide: begin
                    ack           <= 1'b1;
                    resp.accepted <= accept;
                    state         <= st_respond;
                end
                st_respond: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_release;
                    end
                end
                st_release: state <= st_idle;
                st_step:    state <= st_strike;
                st_strike:  state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

endmodule

/* verilog/game_engine.sv */
`timescale 1ns/1ns

module game_engine #(
    parameter int SLOTS    = 8,
    parameter int TOWER_HP = 4000
) (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 tick,
    input  logic                 req,
    input  engine_pkg::cmd_t     cmd,
    output logic                 ack,
    output engine_pkg::resp_t    resp,
    output logic                 busy,
    output engine_pkg::money_t   money,
    output engine_pkg::level_t   purse_level,
    output engine_pkg::hp_t      tower_hp_enemy,
    output engine_pkg::hp_t      tower_hp_army,
    output logic [3:0]           enemy_count,
    output logic [3:0]           army_count,
    output logic                 game_win,
    output logic                 game_lose
);

    logic                      step;
    logic                      strike;
    logic                      enemy_spawn;
    logic                      army_spawn;
    engine_pkg::enemy_unit_t   enemy_payload;
    engine_pkg::army_unit_t    army_payload;
    logic                      enemy_has_free;
    logic                      army_has_free;
    logic                      buy;
    engine_pkg::army_kind_t    buy_kind;
    logic                      upgrade;
    logic                      can_afford;
    logic                      can_upgrade;
    logic                      game_over;
    engine_pkg::hp_t           enemy_total;
    engine_pkg::hp_t           army_total;

    engine_sequencer engine_sequencer_inst (
        .clk_25MHz      (clk_25MHz),
        .rst            (rst),
        .tick           (tick),
        .req            (req),
        .cmd            (cmd),
        .enemy_has_free (enemy_has_free),
        .army_has_free  (army_has_free),
        .can_afford     (can_afford),
        .can_upgrade    (can_upgrade),
        .game_over      (game_over),
        .ack            (ack),
        .resp           (resp),
        .busy           (busy),
        .step           (step),
        .strike         (strike),
        .enemy_spawn    (enemy_spawn),
        .enemy_payload  (enemy_payload),
        .army_spawn     (army_spawn),
        .army_payload   (army_payload),
        .buy            (buy),
        .buy_kind       (buy_kind),
        .upgrade        (upgrade)
    );

    unit_roster #(
        .payload_t (engine_pkg::enemy_unit_t),
        .SLOTS     (SLOTS)
    ) enemy_roster (
        .clk_25MHz    (clk_25MHz),
        .rst          (rst),
        .step         (step),
        .spawn        (enemy_spawn),
        .payload      (enemy_payload),
        .has_free     (enemy_has_free),
        .count        (enemy_count),
        .strike_total (enemy_total)
    );

    unit_roster #(
        .payload_t (engine_pkg::army_unit_t),
        .SLOTS     (SLOTS)
    ) army_roster (
        .clk_25MHz    (clk_25MHz),
        .rst          (rst),
        .step         (step),
        .spawn        (army_spawn),
        .payload      (army_payload),
        .has_free     (army_has_free),
        .count        (army_count),
        .strike_total (army_total)
    );

    purse_ledger purse_ledger_inst (
        .clk_25MHz   (clk_25MHz),
        .rst         (rst),
        .step        (step),
        .buy         (buy),
        .buy_kind    (buy_kind),
        .upgrade     (upgrade),
        .can_afford  (can_afford),
        .can_upgrade (can_upgrade),
        .money       (money),
        .purse_level (purse_level)
    );

    tower_ledger #(
        .TOWER_HP (TOWER_HP)
    ) tower_ledger_inst (
        .clk_25MHz      (clk_25MHz),
        .rst            (rst),
        .strike         (strike),
        .enemy_total    (enemy_total),
        .army_total     (army_total),
        .tower_hp_enemy (tower_hp_enemy),
        .tower_hp_army  (tower_hp_army),
        .game_win       (game_win),
        .game_lose      (game_lose),
        .game_over      (game_over)
    );

endmodule

/* verilog/purse_ledger.sv */
`timescale 1ns/1ns

module purse_ledger (
    input  logic                    clk_25MHz,
    input  logic                    rst,
    input  logic                    step,
    input  logic                    buy,
    input  engine_pkg::army_kind_t  buy_kind,
    input  logic                    upgrade,
    output logic                    can_afford,
    output logic                    can_upgrade,
    output engine_pkg::money_t      money,
    output engine_pkg::level_t      purse_level
);

    engine_pkg::money_t  cap;
    engine_pkg::money_t  earned;
    engine_pkg::money_t  price;
    engine_pkg::money_t  up_cost;

    assign cap     = engine_pkg::money_cap(purse_level);
    assign earned  = money + engine_pkg::income(purse_level);
    assign price   = engine_pkg::army_cost(buy_kind);
    assign up_cost = engine_pkg::upgrade_cost(purse_level);

    assign can_afford  = (money >= price);
    assign can_upgrade = (purse_level != 3'd7) && (money >= up_cost);

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            money       <= '0;
            purse_level <= '0;
        end else if (step) begin
            money <= (earned > cap) ? cap : earned;  // clamp to level cap
        end else if (buy) begin
            money <= money - price;
        end else if (upgrade) begin
            money       <= money - up_cost;
            purse_level <= purse_level + 3'd1;
        end
    end

endmodule

/* verilog/tower_ledger.sv */
`timescale 1ns/1ns

module tower_ledger #(
    parameter int TOWER_HP = 4000
) (
    input  logic             clk_25MHz,
    input  logic             rst,
    input  logic             strike,
    input  engine_pkg::hp_t  enemy_total,
    input  engine_pkg::hp_t  army_total,
    output engine_pkg::hp_t  tower_hp_enemy,
    output engine_pkg::hp_t  tower_hp_army,
    output logic             game_win,
    output logic             game_lose,
    output logic             game_over
);

    // enemy units hit the army tower and the other way round
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            tower_hp_enemy <= engine_pkg::hp_t'(TOWER_HP);
            tower_hp_army  <= engine_pkg::hp_t'(TOWER_HP);
        end else if (strike) begin
            tower_hp_army  <= (enemy_total >= tower_hp_army) ? '0 : tower_hp_army - enemy_total;
            tower_hp_enemy <= (army_total >= tower_hp_enemy) ? '0 : tower_hp_enemy - army_total;
        end
    end

    assign game_win  = (tower_hp_enemy == '0);
    assign game_lose = (tower_hp_army == '0);
    assign game_over = game_win || game_lose;

endmodule

/* verilog/unit_roster.sv */
`timescale 1ns/1ns

module unit_roster #(
    parameter type payload_t = engine_pkg::enemy_unit_t,
    parameter int  SLOTS     = 8
) (
    input  logic             clk_25MHz,
    input  logic             rst,
    input  logic             step,
    input  logic             spawn,
    input  payload_t         payload,
    output logic             has_free,
    output logic [3:0]       count,
    output engine_pkg::hp_t  strike_total
);

    localparam int IDX_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    payload_t                slot_q [SLOTS];
    logic [SLOTS-1:0]        alive_q;
    logic [IDX_W-1:0]        free_idx;
    engine_pkg::hp_t         power_sum;

    assign has_free = ~&alive_q;

    always_comb begin
        free_idx  = '0;
        count     = '0;
        power_sum = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (!alive_q[i]) free_idx = IDX_W'(i);  // lowest index wins
        end
        for (int i = 0; i < SLOTS; i++) begin
            if (alive_q[i]) begin
                count     = count + 4'd1;
                power_sum = power_sum + engine_pkg::hp_t'(slot_q[i].power);
            end
        end
    end

    // unit payloads
    always_ff @(posedge clk_25MHz) begin
        if (step) begin
            for (int i = 0; i < SLOTS; i++) begin
                if (alive_q[i]) slot_q[i].life <= slot_q[i].life - engine_pkg::life_t'(1);
            end
        end else if (spawn && has_free) begin
            slot_q[free_idx] <= payload;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            alive_q      <= '0;
            strike_total <= '0;
        end else if (step) begin
            strike_total <= power_sum;  // strikes before aging
            for (int i = 0; i < SLOTS; i++) begin
                if (alive_q[i] && slot_q[i].life <= engine_pkg::life_t'(1)) alive_q[i] <= 1'b0;
            end
        end else if (spawn && has_free) begin
            alive_q[free_idx] <= 1'b1;
        end
    end

endmodule
